// ==== bench/exu_tb.sv ====
`include "exu_macros.svh"

module exu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_INSTR     = 2000;
  localparam int WDOG_CYCLES = N_INSTR * 12;

  logic clk, rst, in_valid_i, ready_o, valid_o, next_ready_i;
  logic [6:0] opcode_i;
  exu_pkg::alu_op_e alu_op_i;
  exu_pkg::xlen_t imm_i, pc_i, op1_i, op2_i, base_i, rd_wdata_o, redirect_pc_o;
  exu_pkg::xlen_t mem_addr_o, mem_wdata_o, mem_rdata_i;
  logic [4:0] rd_i, rd_o;
  logic rd_wen_i, rd_wen_o, redirect_o, ebreak_o;
  logic mem_req_o, mem_we_o, mem_rvalid_i, mem_wready_i;

  exu_pkg::xlen_t resp_mem [exu_pkg::xlen_t];
  int results;

  exu_top exu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##############################
  // compare tasks
  task automatic check_word(input string name, input exu_pkg::xlen_t got, exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_rd(input string name, input logic [4:0] got, exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    #(WDOG_CYCLES * 20);
    $display("watchdog expired, no result arrived in time");
    $display("TEST FAILED");
    $fatal(1);
  end

  // random back-pressure.
  initial begin
    next_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      next_ready_i <= $urandom_range(9, 0) < 7;
    end
  end

  // every downstream handshake counts as one result.
  initial begin
    results = 0;
    forever begin
      @(posedge clk);
      if (!rst && valid_o && next_ready_i) begin
        results++;
      end
    end
  end

  // ##############################
  // memory responder
  initial begin
    bit replied;
    bit armed;
    int delay;
    replied = 0;
    armed = 0;
    delay = 0;
    mem_rvalid_i = 1'b0;
    mem_wready_i = 1'b0;
    mem_rdata_i  = '0;
    forever begin
      @(posedge clk);
      mem_rvalid_i <= 1'b0;
      mem_wready_i <= 1'b0;
      if (!mem_req_o) begin
        replied = 0;
        armed = 0;
      end else if (!replied) begin
        if (!armed) begin
          armed = 1;
          delay = $urandom_range(5, 0);
        end
        if (delay == 0) begin
          if (mem_we_o) begin
            resp_mem[mem_addr_o] = mem_wdata_o;
            mem_wready_i <= 1'b1;
          end else begin
            mem_rdata_i  <= resp_mem.exists(mem_addr_o) ? resp_mem[mem_addr_o]
                                                        : exu_tb_pkg::mem_fill(mem_addr_o);
            mem_rvalid_i <= 1'b1;
          end
          replied = 1;
        end else begin
          delay--;
        end
      end
    end
  end

  // ##############################
  // stimulus and checking
  initial begin
    exu_tb_pkg::instr_t  ins;
    exu_tb_pkg::expect_t e;
    bit accepted;
    bit done;
    bit first;
    void'($urandom(23715));
    rst = 1'b1;
    in_valid_i = 1'b0;
    opcode_i = `EXU_OP_OP;
    alu_op_i = exu_pkg::alu_add;
    {imm_i, pc_i, op1_i, op2_i, base_i} = '0;
    rd_i = '0;
    rd_wen_i = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("mem_req_o", mem_req_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b1);
    for (int i = 0; i < N_INSTR; i++) begin
      repeat ($urandom_range(2, 0)) @(posedge clk);
      ins = exu_tb_pkg::random_instr();
      e   = exu_tb_pkg::predict(ins);
      in_valid_i <= 1'b1;
      opcode_i <= ins.opcode;
      alu_op_i <= ins.alu_op;
      imm_i    <= ins.imm;
      pc_i     <= ins.pc;
      op1_i    <= ins.op1;
      op2_i    <= ins.op2;
      base_i   <= ins.base;
      rd_i     <= ins.rd;
      rd_wen_i <= ins.rd_wen;
      accepted = 0;
      while (!accepted) begin
        @(posedge clk);
        check_flag("valid_o", valid_o, 1'b0); // no repeated result.
        accepted = ready_o;
      end
      in_valid_i <= 1'b0;
      done = 0;
      first = 1;
      while (!done) begin
        @(posedge clk);
        if (first) begin
          check_flag("valid_o", valid_o, !e.is_mem); // cycle after acceptance.
          check_flag("mem_req_o", mem_req_o, e.is_mem);
          first = 0;
        end
        if (mem_req_o) begin
          check_flag("mem_req_o", mem_req_o, e.is_mem);
          check_flag("mem_we_o", mem_we_o, e.mem_we);
          check_word("mem_addr_o", mem_addr_o, e.mem_addr);
          if (e.mem_we) check_word("mem_wdata_o", mem_wdata_o, ins.op2);
        end
        if (valid_o && next_ready_i) begin
          check_rd("rd_o", rd_o, ins.rd);
          check_flag("rd_wen_o", rd_wen_o, ins.rd_wen);
          check_word("rd_wdata_o", rd_wdata_o, e.wdata);
          check_flag("redirect_o", redirect_o, e.redirect);
          check_flag("ebreak_o", ebreak_o, e.ebreak);
          if (e.redirect && !e.ebreak) check_word("redirect_pc_o", redirect_pc_o, e.redirect_pc);
          done = 1;
        end
      end
    end
    @(posedge clk);
    if (results != N_INSTR) begin
      $display("result count does not match the number of instructions");
      $display("TEST FAILED");
      $fatal(1);
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== bench/exu_tb_pkg.sv ====
`include "exu_macros.svh"

package exu_tb_pkg;

  typedef struct {
    logic [6:0]       opcode;
    exu_pkg::alu_op_e alu_op;
    exu_pkg::xlen_t   imm;
    exu_pkg::xlen_t   pc;
    exu_pkg::xlen_t   op1;
    exu_pkg::xlen_t   op2;
    exu_pkg::xlen_t   base;
    logic [4:0]       rd;
    logic             rd_wen;
  } instr_t;

  typedef struct {
    exu_pkg::xlen_t wdata;
    logic           redirect;
    exu_pkg::xlen_t redirect_pc;
    logic           ebreak;
    logic           is_mem;
    logic           mem_we;
    exu_pkg::xlen_t mem_addr;
  } expect_t;

  // ##############################
  // model state
  exu_pkg::xlen_t mstatus = '0;
  exu_pkg::xlen_t mtvec   = `EXU_MTVEC_RESET;
  exu_pkg::xlen_t mepc    = '0;
  exu_pkg::xlen_t mcause  = '0;
  exu_pkg::xlen_t mem_model [exu_pkg::xlen_t];

  function automatic exu_pkg::xlen_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  // contents of a word never stored.
  function automatic exu_pkg::xlen_t mem_fill(input exu_pkg::xlen_t addr);
    return addr ^ {addr[31:0], addr[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
  endfunction

  function automatic exu_pkg::xlen_t alu_model(input exu_pkg::alu_op_e op,
                                               input exu_pkg::xlen_t a, b);
    case (op)
      exu_pkg::alu_add:  return a + b;
      exu_pkg::alu_sub:  return a - b;
      exu_pkg::alu_and:  return a & b;
      exu_pkg::alu_or:   return a | b;
      exu_pkg::alu_xor:  return a ^ b;
      exu_pkg::alu_sll:  return a << b[5:0];
      exu_pkg::alu_srl:  return a >> b[5:0];
      exu_pkg::alu_sra:  return $signed(a) >>> b[5:0];
      exu_pkg::alu_slt:  return {63'd0, $signed(a) < $signed(b)};
      exu_pkg::alu_sltu: return {63'd0, a < b};
      exu_pkg::alu_sle:  return {63'd0, $signed(a) <= $signed(b)};
      exu_pkg::alu_sleu: return {63'd0, a <= b};
      default:           return '0;
    endcase
  endfunction

  function automatic logic taken(input exu_pkg::alu_op_e op, input exu_pkg::xlen_t a, b);
    case (op)
      exu_pkg::alu_sub:  return a == b;
      exu_pkg::alu_xor:  return a != b;
      exu_pkg::alu_slt:  return $signed(a) < $signed(b);
      exu_pkg::alu_sltu: return a < b;
      exu_pkg::alu_sle:  return $signed(a) <= $signed(b);
      exu_pkg::alu_sleu: return a <= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic exu_pkg::xlen_t csr_read(input logic [11:0] addr);
    case (addr)
      `EXU_CSR_MSTATUS: return mstatus;
      `EXU_CSR_MTVEC:   return mtvec;
      `EXU_CSR_MEPC:    return mepc;
      `EXU_CSR_MCAUSE:  return mcause;
      default:          return '0;
    endcase
  endfunction

  function automatic void csr_write(input logic [11:0] addr, input exu_pkg::xlen_t v);
    case (addr)
      `EXU_CSR_MSTATUS: mstatus = v;
      `EXU_CSR_MTVEC:   mtvec = v;
      `EXU_CSR_MEPC:    mepc = v;
      `EXU_CSR_MCAUSE:  mcause = v;
      default:          ;
    endcase
  endfunction

  // ##############################
  // random instruction
  function automatic instr_t random_instr();
    instr_t        ins;
    exu_pkg::imm_u imm;
    int            kind;
    logic [3:0]    fns [6] = '{4'h1, 4'h2, 4'h3, 4'h5, 4'h6, 4'h7};
    logic [11:0]   adrs [5] = '{12'h300, 12'h305, 12'h341, 12'h342, 12'h7c0};
    logic [11:0]   traps [3] = '{`EXU_SYS_ECALL, `EXU_SYS_MRET, `EXU_SYS_EBREAK};
    kind       = $urandom_range(9, 0);
    ins.alu_op = exu_pkg::alu_op_e'($urandom_range(11, 0));
    ins.pc     = rand_word() << 2;
    ins.op1    = rand_word();
    ins.op2    = ($urandom_range(3, 0) == 0) ? ins.op1 : rand_word();
    ins.base   = rand_word();
    ins.imm    = rand_word();
    ins.rd     = $urandom_range(31, 0);
    ins.rd_wen = $urandom_range(1, 0);
    imm.raw    = '0;
    case (kind)
      4:       ins.opcode = `EXU_OP_BRANCH;
      5:       ins.opcode = $urandom_range(1, 0) ? `EXU_OP_JAL : `EXU_OP_JALR;
      6, 7: begin
        ins.opcode = (kind == 6) ? `EXU_OP_LOAD : `EXU_OP_STORE;
        ins.base   = 64'h1000 + 64'($urandom_range(63, 0)) * 8;
        ins.imm    = 64'($urandom_range(15, 0)) * 8;
      end
      8: begin
        ins.opcode      = `EXU_OP_SYSTEM;
        imm.sys.sys_fn  = fns[$urandom_range(5, 0)];
        imm.sys.funct12 = adrs[$urandom_range(4, 0)];
        if (imm.sys.sys_fn[2]) ins.op1 = 64'($urandom_range(31, 0)); // zimm.
        ins.imm = imm.raw;
      end
      9: begin
        ins.opcode      = `EXU_OP_SYSTEM;
        imm.sys.funct12 = traps[$urandom_range(2, 0)];
        ins.imm         = imm.raw;
      end
      default: ins.opcode = `EXU_OP_OP;
    endcase
    return ins;
  endfunction

  // expected result; also commits the model state.
  function automatic expect_t predict(input instr_t ins);
    expect_t        e;
    exu_pkg::imm_u  imm;
    exu_pkg::xlen_t old;
    exu_pkg::xlen_t nv;
    imm           = ins.imm;
    e.wdata       = alu_model(ins.alu_op, ins.op1, ins.op2);
    e.redirect    = 1'b0;
    e.redirect_pc = ins.base + ins.imm;
    e.ebreak      = 1'b0;
    e.is_mem      = ins.opcode inside {`EXU_OP_LOAD, `EXU_OP_STORE};
    e.mem_we      = ins.opcode == `EXU_OP_STORE;
    e.mem_addr    = ins.base + ins.imm;
    case (ins.opcode)
      `EXU_OP_BRANCH: e.redirect = taken(ins.alu_op, ins.op1, ins.op2);
      `EXU_OP_JAL, `EXU_OP_JALR: e.redirect = 1'b1;
      `EXU_OP_LOAD: begin
        e.wdata = mem_model.exists(e.mem_addr) ? mem_model[e.mem_addr] : mem_fill(e.mem_addr);
      end
      `EXU_OP_STORE: mem_model[e.mem_addr] = ins.op2;
      `EXU_OP_SYSTEM: begin
        if (imm.sys.sys_fn == `EXU_SYS_PRIV) begin
          e.redirect = 1'b1;
          if (imm.sys.funct12 == `EXU_SYS_ECALL) begin
            e.wdata       = mcause;
            e.redirect_pc = mtvec;
            mcause        = `EXU_CAUSE_ECALL;
            mepc          = ins.pc;
          end else if (imm.sys.funct12 == `EXU_SYS_MRET) begin
            e.wdata       = mstatus;
            e.redirect_pc = mepc;
            mstatus[`EXU_MSTATUS_MIE]  = mstatus[`EXU_MSTATUS_MPIE];
            mstatus[`EXU_MSTATUS_MPIE] = 1'b1;
          end else begin
            e.wdata  = csr_read(imm.sys.funct12);
            e.ebreak = 1'b1;
          end
        end else begin
          old = csr_read(imm.sys.funct12);
          case (imm.sys.sys_fn[1:0])
            2'd1:    nv = ins.op1;
            2'd2:    nv = old | ins.op1;
            default: nv = old & ~ins.op1;
          endcase
          e.wdata = old;
          csr_write(imm.sys.funct12, nv);
        end
      end
      default: ;
    endcase
    return e;
  endfunction

endpackage

// ==== src/exu_alu.sv ====
module exu_alu (
  input  exu_pkg::xlen_t   src1_i,
  input  exu_pkg::xlen_t   src2_i,
  input  exu_pkg::alu_op_e op_i,
  output exu_pkg::xlen_t   res_o
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[5:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::alu_add: begin
        res_o = src1_i + src2_i;
      end
      exu_pkg::alu_sub: begin
        res_o = src1_i - src2_i;
      end
      exu_pkg::alu_and: begin
        res_o = src1_i & src2_i;
      end
      exu_pkg::alu_or: begin
        res_o = src1_i | src2_i;
      end
      exu_pkg::alu_xor: begin
        res_o = src1_i ^ src2_i;
      end
      exu_pkg::alu_sll: begin
        res_o = src1_i << shamt;
      end
      exu_pkg::alu_srl: begin
        res_o = src1_i >> shamt;
      end
      exu_pkg::alu_sra: begin
        res_o = $signed(src1_i) >>> shamt;
      end
      // compares give 0 or 1.
      exu_pkg::alu_slt: begin
        res_o[0] = lt_s;
      end
      exu_pkg::alu_sltu: begin
        res_o[0] = lt_u;
      end
      exu_pkg::alu_sle: begin
        res_o[0] = lt_s | eq;
      end
      exu_pkg::alu_sleu: begin
        res_o[0] = lt_u | eq;
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// ==== src/exu_core.sv ====
`include "exu_macros.svh"

module exu_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid_i,
  output logic             ready_o,
  input  logic [6:0]       opcode_i,
  input  exu_pkg::alu_op_e alu_op_i,
  input  exu_pkg::xlen_t   imm_i,
  input  exu_pkg::xlen_t   pc_i,
  input  exu_pkg::xlen_t   op1_i,
  input  exu_pkg::xlen_t   op2_i,
  input  exu_pkg::xlen_t   base_i,
  input  logic [4:0]       rd_i,
  input  logic             rd_wen_i,
  output logic             valid_o,
  input  logic             next_ready_i,
  output logic [4:0]       rd_o,
  output logic             rd_wen_o,
  output exu_pkg::xlen_t   rd_wdata_o,
  output logic             redirect_o,
  output exu_pkg::xlen_t   redirect_pc_o,
  output logic             ebreak_o,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output exu_pkg::xlen_t   mem_addr_o,
  output exu_pkg::xlen_t   mem_wdata_o,
  input  logic             mem_rvalid_i,
  input  logic             mem_wready_i,
  input  exu_pkg::xlen_t   mem_rdata_i,
  exu_csr_if.core          csr
);

  typedef enum logic [1:0] {st_idle, st_mem, st_done} state_e;

  state_e           state_q;
  logic [6:0]       opcode_q;
  exu_pkg::alu_op_e alu_op_q;
  exu_pkg::imm_u    imm_q;
  exu_pkg::xlen_t   pc_q;
  exu_pkg::xlen_t   op1_q;
  exu_pkg::xlen_t   op2_q;
  exu_pkg::xlen_t   addr_q;
  exu_pkg::xlen_t   mem_rdata_q;
  exu_pkg::xlen_t   alu_res;
  exu_pkg::xlen_t   mret_val;
  exu_pkg::wb_sel_e wb_sel;

  logic accept;
  logic is_mem_in;
  logic is_store_q;
  logic mem_done;
  logic is_sys, is_priv, is_ecall, is_mret, is_ebreak, is_csr_op;

  assign accept     = in_valid_i && ready_o;
  assign is_mem_in  = (opcode_i == `EXU_OP_LOAD) || (opcode_i == `EXU_OP_STORE);
  assign is_store_q = opcode_q == `EXU_OP_STORE;
  assign mem_done   = is_store_q ? mem_wready_i : mem_rvalid_i;

  // ##############################
  // handshake fsm, one instruction in flight.
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (accept) state_q <= is_mem_in ? st_mem : st_done;
        st_mem:  if (mem_done) state_q <= st_done;
        st_done: if (next_ready_i) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_q <= opcode_i;
      alu_op_q <= alu_op_i;
      imm_q    <= imm_i;
      pc_q     <= pc_i;
      op1_q    <= op1_i;
      op2_q    <= op2_i;
      addr_q   <= base_i + imm_i; // load/store and jump target.
      rd_o     <= rd_i;
      rd_wen_o <= rd_wen_i;
    end
    if (state_q == st_mem && mem_rvalid_i && !is_store_q) begin
      mem_rdata_q <= mem_rdata_i;
    end
  end

  assign ready_o     = state_q == st_idle;
  assign valid_o     = state_q == st_done;
  assign mem_req_o   = state_q == st_mem;  // level until the reply strobe.
  assign mem_we_o    = is_store_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = op2_q;

  exu_alu u_alu (
    .src1_i (op1_q),
    .src2_i (op2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  // ##############################
  // writeback select
  always_comb begin
    wb_sel = exu_pkg::wb_alu;
    if (opcode_q == `EXU_OP_LOAD) wb_sel = exu_pkg::wb_mem;
    else if (is_sys) wb_sel = exu_pkg::wb_csr;
  end

  always_comb begin
    case (wb_sel)
      exu_pkg::wb_mem: rd_wdata_o = mem_rdata_q;
      exu_pkg::wb_csr: rd_wdata_o = csr.rdata;   // old csr value.
      default:         rd_wdata_o = alu_res;
    endcase
  end

  // ##############################
  // csr operation
  assign is_sys    = opcode_q == `EXU_OP_SYSTEM;
  assign is_priv   = is_sys && (imm_q.sys.sys_fn == `EXU_SYS_PRIV);
  assign is_ecall  = is_priv && (imm_q.sys.funct12 == `EXU_SYS_ECALL);
  assign is_ebreak = is_priv && (imm_q.sys.funct12 == `EXU_SYS_EBREAK);
  assign is_mret   = is_priv && (imm_q.sys.funct12 == `EXU_SYS_MRET);
  assign is_csr_op = is_sys && (imm_q.sys.sys_fn inside {`EXU_SYS_CSRRW, `EXU_SYS_CSRRS,
    `EXU_SYS_CSRRC, `EXU_SYS_CSRRWI, `EXU_SYS_CSRRSI, `EXU_SYS_CSRRCI});

  always_comb begin
    csr.raddr = imm_q.sys.funct12;
    if (is_ecall) csr.raddr = `EXU_CSR_MCAUSE;
    else if (is_mret) csr.raddr = `EXU_CSR_MSTATUS;
  end

  always_comb begin
    mret_val = csr.rdata;
    mret_val[`EXU_MSTATUS_MIE]  = csr.rdata[`EXU_MSTATUS_MPIE];
    mret_val[`EXU_MSTATUS_MPIE] = 1'b1;
  end

  // immediate forms get zimm in op1 from decode.
  always_comb begin
    case (imm_q.sys.sys_fn)
      `EXU_SYS_PRIV:                  csr.wdata = is_ecall ? `EXU_CAUSE_ECALL : mret_val;
      `EXU_SYS_CSRRW, `EXU_SYS_CSRRWI: csr.wdata = op1_q;
      `EXU_SYS_CSRRS, `EXU_SYS_CSRRSI: csr.wdata = csr.rdata | op1_q;
      `EXU_SYS_CSRRC, `EXU_SYS_CSRRCI: csr.wdata = csr.rdata & ~op1_q;
      default:                        csr.wdata = csr.rdata;
    endcase
  end

  assign csr.waddr     = csr.raddr;
  assign csr.wen       = valid_o && (is_ecall || is_mret || is_csr_op);
  assign csr.aux_wen   = valid_o && is_ecall;
  assign csr.aux_waddr = `EXU_CSR_MEPC;
  assign csr.aux_wdata = pc_q;     // trap return address.

  // ##############################
  // next-pc redirect, from the captured opcode.
  always_comb begin
    redirect_o    = 1'b0;
    redirect_pc_o = addr_q;
    ebreak_o      = 1'b0;
    case (opcode_q)
      `EXU_OP_JAL, `EXU_OP_JALR: redirect_o = 1'b1;
      `EXU_OP_BRANCH: begin
        case (alu_op_q)
          exu_pkg::alu_sub:  redirect_o = ~|alu_res; // equal.
          exu_pkg::alu_xor,
          exu_pkg::alu_slt,
          exu_pkg::alu_sltu,
          exu_pkg::alu_sle,
          exu_pkg::alu_sleu: redirect_o = |alu_res;
          default:           redirect_o = 1'b0;
        endcase
      end
      `EXU_OP_SYSTEM: begin
        if (is_ecall) begin
          redirect_o    = 1'b1;
          redirect_pc_o = csr.mtvec;
        end else if (is_mret) begin
          redirect_o    = 1'b1;
          redirect_pc_o = csr.mepc;
        end else if (is_ebreak) begin
          redirect_o = 1'b1;
          ebreak_o   = 1'b1;
        end
      end
      default: redirect_o = 1'b0;
    endcase
  end

  // result held under back-pressure.
  a_hold_result: assert property (
    @(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && $stable(rd_wdata_o)
  );

  // a request is only open for a captured load or store.
  a_mem_req_opcode: assert property (
    @(posedge clk) disable iff (rst)
    mem_req_o |-> (opcode_q == `EXU_OP_LOAD) || (opcode_q == `EXU_OP_STORE)
  );

endmodule

// ==== src/exu_csr_file.sv ====
`include "exu_macros.svh"

module exu_csr_file (
  input  logic   clk,
  input  logic   rst,
  exu_csr_if.file csr,
  input  logic   commit_i
);

  localparam logic [1:0] IDX_MSTATUS = 2'd0;
  localparam logic [1:0] IDX_MTVEC   = 2'd1;
  localparam logic [1:0] IDX_MEPC    = 2'd2;
  localparam logic [1:0] IDX_MCAUSE  = 2'd3;

  exu_pkg::xlen_t csr_q [4];

  logic [2:0] main_sel;
  logic [2:0] aux_sel;
  logic [2:0] rd_sel;

  // {hit, index} for an address.
  function automatic logic [2:0] csr_index(input logic [11:0] addr);
    logic [2:0] sel;
    case (addr)
      `EXU_CSR_MSTATUS: sel = {1'b1, IDX_MSTATUS};
      `EXU_CSR_MTVEC:   sel = {1'b1, IDX_MTVEC};
      `EXU_CSR_MEPC:    sel = {1'b1, IDX_MEPC};
      `EXU_CSR_MCAUSE:  sel = {1'b1, IDX_MCAUSE};
      default:          sel = 3'b000;
    endcase
    return sel;
  endfunction

  assign main_sel = csr_index(csr.waddr);
  assign aux_sel  = csr_index(csr.aux_waddr);
  assign rd_sel   = csr_index(csr.raddr);

  // ##############################
  // writes land on the downstream handshake.
  always_ff @(posedge clk) begin
    if (rst) begin
      csr_q[IDX_MSTATUS] <= '0;
      csr_q[IDX_MTVEC]   <= `EXU_MTVEC_RESET;
      csr_q[IDX_MEPC]    <= '0;
      csr_q[IDX_MCAUSE]  <= '0;
    end else if (commit_i) begin
      if (csr.wen && main_sel[2]) begin
        csr_q[main_sel[1:0]] <= csr.wdata;
      end
      if (csr.aux_wen && aux_sel[2]) begin
        csr_q[aux_sel[1:0]] <= csr.aux_wdata;
      end
    end
  end

  // ##############################
  // combinational read.
  assign csr.rdata = rd_sel[2] ? csr_q[rd_sel[1:0]] : '0; // unknown reads as zero.
  assign csr.mepc  = csr_q[IDX_MEPC];
  assign csr.mtvec = csr_q[IDX_MTVEC];

  // the core never points both write ports at one register.
  a_no_dual_write: assert property (
    @(posedge clk) disable iff (rst)
    !(csr.wen && csr.aux_wen && (csr.waddr == csr.aux_waddr))
  );

endmodule

// ==== src/exu_csr_if.sv ====
interface exu_csr_if;

  logic           wen;
  logic [11:0]    waddr;
  exu_pkg::xlen_t wdata;
  logic           aux_wen;   // second write port, trap entry.
  logic [11:0]    aux_waddr;
  exu_pkg::xlen_t aux_wdata;
  logic [11:0]    raddr;
  exu_pkg::xlen_t rdata;
  exu_pkg::xlen_t mepc;
  exu_pkg::xlen_t mtvec;

  modport core (
    output wen, waddr, wdata,
    output aux_wen, aux_waddr, aux_wdata,
    output raddr,
    input  rdata, mepc, mtvec
  );

  modport file (
    input  wen, waddr, wdata,
    input  aux_wen, aux_waddr, aux_wdata,
    input  raddr,
    output rdata, mepc, mtvec
  );

endinterface

// ==== src/exu_macros.svh ====
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// ##############################
// data path
`define EXU_XLEN         64
`define EXU_MTVEC_RESET  64'h0000_0000_8000_0000

// ##############################
// major opcodes
`define EXU_OP_LOAD      7'b0000011
`define EXU_OP_STORE     7'b0100011
`define EXU_OP_BRANCH    7'b1100011
`define EXU_OP_JAL       7'b1101111
`define EXU_OP_JALR      7'b1100111
`define EXU_OP_OP        7'b0110011
`define EXU_OP_SYSTEM    7'b1110011

// ##############################
// system function codes, low nibble of the immediate
`define EXU_SYS_PRIV     4'h0
`define EXU_SYS_CSRRW    4'h1
`define EXU_SYS_CSRRS    4'h2
`define EXU_SYS_CSRRC    4'h3
`define EXU_SYS_CSRRWI   4'h5
`define EXU_SYS_CSRRSI   4'h6
`define EXU_SYS_CSRRCI   4'h7

`define EXU_SYS_ECALL    12'h000
`define EXU_SYS_EBREAK   12'h001
`define EXU_SYS_MRET     12'h302

// ##############################
// machine csrs
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

`define EXU_CAUSE_ECALL  64'd11
`define EXU_MSTATUS_MIE  3
`define EXU_MSTATUS_MPIE 7

`endif

// ==== src/exu_pkg.sv ====
`include "exu_macros.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] xlen_t;

  // ##############################
  // alu operations
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_sle  = 4'd10,
    alu_sleu = 4'd11
  } alu_op_e;

  // ##############################
  // immediate word, seen as an operand or as system fields
  typedef struct packed {
    logic [`EXU_XLEN-17:0] unused;
    logic [11:0]           funct12; // funct12 or csr address.
    logic [3:0]            sys_fn;
  } sys_fields_t;

  typedef union packed {
    xlen_t       raw;
    sys_fields_t sys;
  } imm_u;

  // ##############################
  // writeback source
  typedef enum logic [1:0] {
    wb_alu = 2'd0,
    wb_mem = 2'd1,
    wb_csr = 2'd2
  } wb_sel_e;

endpackage

// ==== src/exu_top.sv ====
module exu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid_i,
  output logic             ready_o,
  input  logic [6:0]       opcode_i,
  input  exu_pkg::alu_op_e alu_op_i,
  input  exu_pkg::xlen_t   imm_i,
  input  exu_pkg::xlen_t   pc_i,
  input  exu_pkg::xlen_t   op1_i,
  input  exu_pkg::xlen_t   op2_i,
  input  exu_pkg::xlen_t   base_i,
  input  logic [4:0]       rd_i,
  input  logic             rd_wen_i,
  output logic             valid_o,
  input  logic             next_ready_i,
  output logic [4:0]       rd_o,
  output logic             rd_wen_o,
  output exu_pkg::xlen_t   rd_wdata_o,
  output logic             redirect_o,
  output exu_pkg::xlen_t   redirect_pc_o,
  output logic             ebreak_o,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output exu_pkg::xlen_t   mem_addr_o,
  output exu_pkg::xlen_t   mem_wdata_o,
  input  logic             mem_rvalid_i,
  input  logic             mem_wready_i,
  input  exu_pkg::xlen_t   mem_rdata_i
);

  exu_csr_if csr_bus ();

  exu_core u_core (
    .clk, .rst,
    .in_valid_i, .ready_o,
    .opcode_i, .alu_op_i, .imm_i, .pc_i,
    .op1_i, .op2_i, .base_i, .rd_i, .rd_wen_i,
    .valid_o, .next_ready_i,
    .rd_o, .rd_wen_o, .rd_wdata_o,
    .redirect_o, .redirect_pc_o, .ebreak_o,
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
    .mem_rvalid_i, .mem_wready_i, .mem_rdata_i,
    .csr (csr_bus.core)
  );

  // csr writes commit with the downstream handshake.
  exu_csr_file u_csr_file (
    .clk,
    .rst,
    .csr      (csr_bus.file),
    .commit_i (valid_o && next_ready_i)
  );

endmodule

// ==== verilog.f ====
+incdir+src
src/exu_pkg.sv
src/exu_csr_if.sv
src/exu_alu.sv
src/exu_csr_file.sv
src/exu_core.sv
src/exu_top.sv
bench/exu_tb_pkg.sv
bench/exu_tb.sv
